// File: src/hci_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes, register offsets and bus types shared by the
// PIO queue core and its testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package hci_pkg;

  localparam int unsigned NumQueues  = 4;
  localparam int unsigned QueueDepth = 16;
  localparam int unsigned DataWidth  = 32;
  localparam int unsigned LevelWidth = 5;  // Level 0..QueueDepth
  localparam int unsigned PtrWidth   = 4;
  localparam int unsigned ThldWidth  = 8;
  localparam int unsigned AddrWidth  = 12;

  // Queue slots
  localparam int unsigned QCmd  = 0;
  localparam int unsigned QTx   = 1;
  localparam int unsigned QResp = 2;
  localparam int unsigned QRx   = 3;

  // Register byte offsets
  localparam logic [AddrWidth-1:0] RegResetCtrl = 12'h000;
  localparam logic [AddrWidth-1:0] RegQueueThld = 12'h004;
  localparam logic [AddrWidth-1:0] RegDataThld  = 12'h008;
  localparam logic [AddrWidth-1:0] RegCmdPort   = 12'h00C;
  localparam logic [AddrWidth-1:0] RegTxPort    = 12'h010;
  localparam logic [AddrWidth-1:0] RegRespPort  = 12'h014;
  localparam logic [AddrWidth-1:0] RegRxPort    = 12'h018;
  localparam logic [AddrWidth-1:0] RegStatus    = 12'h01C;

  typedef struct packed {
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [AddrWidth-1:0] paddr;
    logic [DataWidth-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic                 pready;
    logic [DataWidth-1:0] prdata;
    logic                 pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic                 valid;
    logic [DataWidth-1:0] data;
  } q_push_t;

  typedef struct packed {
    logic pop;
  } q_pop_t;

  typedef struct packed {
    logic [LevelWidth-1:0] level;
    logic                  full;
    logic                  empty;
    logic [DataWidth-1:0]  head;
  } q_stat_t;

  // One slot per queue
  typedef q_push_t [NumQueues-1:0] q_push_arr_t;
  typedef q_pop_t  [NumQueues-1:0] q_pop_arr_t;
  typedef q_stat_t [NumQueues-1:0] q_stat_arr_t;

endpackage

`default_nettype wire

// File: src/hci_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous FIFO for one PIO queue, with soft flush
// and a fill level for the threshold logic
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module hci_queue (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  input  hci_pkg::q_push_t push_i,
  input  hci_pkg::q_pop_t  pop_i,
  output hci_pkg::q_stat_t stat_o
);
  import hci_pkg::*;

  logic [DataWidth-1:0]  mem_q [QueueDepth];
  logic [PtrWidth-1:0]   wr_ptr_q;
  logic [PtrWidth-1:0]   rd_ptr_q;
  logic [LevelWidth-1:0] level_q;
  logic                  full;
  logic                  empty;
  logic                  push_acc;
  logic                  pop_acc;

  assign full     = (level_q == LevelWidth'(QueueDepth));
  assign empty    = (level_q == '0);
  assign push_acc = push_i.valid && !full;  // Dropped when full
  assign pop_acc  = pop_i.pop && !empty;

  // Pointers wrap naturally at depth 16
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push_acc) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_acc) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_acc, pop_acc})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;  // Both or neither
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_acc) begin
      mem_q[wr_ptr_q] <= push_i.data;
    end
  end

  always_comb begin
    stat_o.level = level_q;
    stat_o.full  = full;
    stat_o.empty = empty;
    stat_o.head  = mem_q[rd_ptr_q];  // Valid only when not empty
  end

  // A full queue holds its write side until a word leaves
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    full && !pop_i.pop && !flush_i |=> full && $stable(wr_ptr_q));

  // An empty queue holds its read side until a word arrives
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    empty && !push_i.valid && !flush_i |=> empty && $stable(rd_ptr_q));

  a_level_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    level_q <= LevelWidth'(QueueDepth));

endmodule

`default_nettype wire

// File: src/hci_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB register block: queue ports, thresholds, soft
// resets, status and the ready threshold triggers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module hci_regs (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  hci_pkg::apb_req_t             apb_i,
  output hci_pkg::apb_rsp_t             apb_o,
  input  hci_pkg::q_stat_arr_t          stat_i,
  output hci_pkg::q_push_arr_t          sw_push_o,
  output hci_pkg::q_pop_arr_t           sw_pop_o,
  output logic [hci_pkg::NumQueues-1:0] flush_o,
  output logic [hci_pkg::NumQueues-1:0] thld_trig_o
);
  import hci_pkg::*;

  logic [NumQueues-1:0][ThldWidth-1:0] thld_q;
  logic [NumQueues-1:0]                rst_ctrl_q;
  logic [NumQueues-1:0]                q_empty;
  logic [NumQueues-1:0]                q_full;
  logic                                access;
  logic                                wr_done;
  logic                                rd_done;
  logic                                stall;
  logic                                mapped;
  logic [DataWidth-1:0]                rdata;

  assign access  = apb_i.psel && apb_i.penable;
  assign wr_done = access && apb_i.pwrite && !stall;
  assign rd_done = access && !apb_i.pwrite && !stall;

  // Offset decode, port stalls and read mux
  always_comb begin
    mapped = 1'b1;
    stall  = 1'b0;
    rdata  = '0;
    case (apb_i.paddr)
      RegResetCtrl: rdata[NumQueues-1:0] = rst_ctrl_q;
      RegQueueThld: rdata = {{(DataWidth-2*ThldWidth){1'b0}}, thld_q[QResp], thld_q[QCmd]};
      RegDataThld:  rdata = {{(DataWidth-2*ThldWidth){1'b0}}, thld_q[QRx], thld_q[QTx]};
      RegCmdPort:   stall = apb_i.pwrite && stat_i[QCmd].full;
      RegTxPort:    stall = apb_i.pwrite && stat_i[QTx].full;
      RegRespPort: begin
        stall = !apb_i.pwrite && stat_i[QResp].empty;
        rdata = stat_i[QResp].head;
      end
      RegRxPort: begin
        stall = !apb_i.pwrite && stat_i[QRx].empty;
        rdata = stat_i[QRx].head;
      end
      RegStatus: rdata = {{(DataWidth-3*NumQueues){1'b0}}, thld_trig_o, q_full, q_empty};
      default:   mapped = 1'b0;
    endcase
  end

  assign apb_o.pready  = access && !stall;
  assign apb_o.pslverr = access && !mapped;
  assign apb_o.prdata  = rd_done ? rdata : '0;  // Zero for unmapped too

  // Software side of the queues
  always_comb begin
    sw_push_o = '0;
    sw_pop_o  = '0;
    sw_push_o[QCmd].valid = wr_done && (apb_i.paddr == RegCmdPort);
    sw_push_o[QCmd].data  = apb_i.pwdata;
    sw_push_o[QTx].valid  = wr_done && (apb_i.paddr == RegTxPort);
    sw_push_o[QTx].data   = apb_i.pwdata;
    sw_pop_o[QResp].pop   = rd_done && (apb_i.paddr == RegRespPort);
    sw_pop_o[QRx].pop     = rd_done && (apb_i.paddr == RegRxPort);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      thld_q     <= '0;
      rst_ctrl_q <= '0;
    end else begin
      rst_ctrl_q <= '0;  // Reset bits last one cycle
      if (wr_done) begin
        case (apb_i.paddr)
          RegResetCtrl: rst_ctrl_q <= apb_i.pwdata[NumQueues-1:0];
          RegQueueThld: begin
            thld_q[QCmd]  <= apb_i.pwdata[ThldWidth-1:0];
            thld_q[QResp] <= apb_i.pwdata[2*ThldWidth-1:ThldWidth];
          end
          RegDataThld: begin
            thld_q[QTx] <= apb_i.pwdata[ThldWidth-1:0];
            thld_q[QRx] <= apb_i.pwdata[2*ThldWidth-1:ThldWidth];
          end
          default: ;
        endcase
      end
    end
  end

  assign flush_o = rst_ctrl_q;

  // Outbound queues count free entries, inbound ones count words
  for (genvar i = 0; i < NumQueues; i++) begin : g_trig
    logic [ThldWidth-1:0] count;

    if (i == QCmd || i == QTx) begin : g_free
      assign count = ThldWidth'(QueueDepth) - ThldWidth'(stat_i[i].level);
    end else begin : g_fill
      assign count = ThldWidth'(stat_i[i].level);
    end

    assign thld_trig_o[i] = (thld_q[i] != '0) && (count >= thld_q[i]);  // Zero disables
    assign q_empty[i]     = stat_i[i].empty;
    assign q_full[i]      = stat_i[i].full;
  end

  // pready only rises in an access phase that followed a setup cycle
  a_pready_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(apb_o.pready) |-> apb_i.psel && apb_i.penable && $past(apb_i.psel));

  // Soft reset empties every chosen queue one cycle later
  a_flush_empties: assert property (@(posedge clk_i) disable iff (!rst_ni)
    |rst_ctrl_q |=> &(q_empty | ~$past(rst_ctrl_q)));

endmodule

`default_nettype wire

// File: src/hci_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PIO queue core: APB registers in front of four
// queues, drained or filled by the controller ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module hci_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  hci_pkg::apb_req_t             apb_i,
  output hci_pkg::apb_rsp_t             apb_o,
  output logic                          cmd_rvalid_o,
  input  logic                          cmd_rready_i,
  output logic [hci_pkg::DataWidth-1:0] cmd_rdata_o,
  output logic                          tx_rvalid_o,
  input  logic                          tx_rready_i,
  output logic [hci_pkg::DataWidth-1:0] tx_rdata_o,
  input  logic                          resp_wvalid_i,
  output logic                          resp_wready_o,
  input  logic [hci_pkg::DataWidth-1:0] resp_wdata_i,
  input  logic                          rx_wvalid_i,
  output logic                          rx_wready_o,
  input  logic [hci_pkg::DataWidth-1:0] rx_wdata_i,
  output logic                          cmd_thld_trig_o,
  output logic                          tx_thld_trig_o,
  output logic                          resp_thld_trig_o,
  output logic                          rx_thld_trig_o
);
  import hci_pkg::*;

  q_push_arr_t          sw_push, hw_push, push;
  q_pop_arr_t           sw_pop, hw_pop, pop;
  q_stat_arr_t          stat;
  logic [NumQueues-1:0] flush;
  logic [NumQueues-1:0] thld_trig;

  hci_regs u_regs (
    .clk_i,
    .rst_ni,
    .apb_i,
    .apb_o,
    .stat_i      (stat),
    .sw_push_o   (sw_push),
    .sw_pop_o    (sw_pop),
    .flush_o     (flush),
    .thld_trig_o (thld_trig)
  );

  // Controller side slots
  always_comb begin
    hw_push = '0;
    hw_pop  = '0;
    hw_push[QResp].valid = resp_wvalid_i;
    hw_push[QResp].data  = resp_wdata_i;
    hw_push[QRx].valid   = rx_wvalid_i;
    hw_push[QRx].data    = rx_wdata_i;
    hw_pop[QCmd].pop     = cmd_rready_i;  // Ignored by the queue when empty
    hw_pop[QTx].pop      = tx_rready_i;
  end

  // Each slot is driven from one side only
  assign push = sw_push | hw_push;
  assign pop  = sw_pop | hw_pop;

  for (genvar i = 0; i < NumQueues; i++) begin : g_queue
    hci_queue u_queue (
      .clk_i,
      .rst_ni,
      .flush_i (flush[i]),
      .push_i  (push[i]),
      .pop_i   (pop[i]),
      .stat_o  (stat[i])
    );
  end

  assign cmd_rvalid_o  = !stat[QCmd].empty;
  assign cmd_rdata_o   = stat[QCmd].head;
  assign tx_rvalid_o   = !stat[QTx].empty;
  assign tx_rdata_o    = stat[QTx].head;
  assign resp_wready_o = !stat[QResp].full;
  assign rx_wready_o   = !stat[QRx].full;

  assign cmd_thld_trig_o  = thld_trig[QCmd];
  assign tx_thld_trig_o   = thld_trig[QTx];
  assign resp_thld_trig_o = thld_trig[QResp];
  assign rx_thld_trig_o   = thld_trig[QRx];

endmodule

`default_nettype wire

// File: include/hci_tb_apb.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB master tasks for the queue core testbench,
// included inside the testbench module
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef HCI_TB_APB_SVH
`define HCI_TB_APB_SVH

// Setup cycle, then access phase until pready; sampled 1 ns after the falling edge
task automatic apb_xfer(input logic wr, input logic [AddrWidth-1:0] addr,
                        input logic [DataWidth-1:0] wdata, output logic [DataWidth-1:0] rdata,
                        output logic err, output logic done);
  int unsigned waits;
  waits = 0;
  @(negedge clk_i);
  apb_req.psel    = 1'b1;
  apb_req.penable = 1'b0;
  apb_req.pwrite  = wr;
  apb_req.paddr   = addr;
  apb_req.pwdata  = wdata;
  @(negedge clk_i);
  apb_req.penable = 1'b1;
  #1;
  while (!apb_rsp.pready && waits < 64) begin  // Stalled port
    @(negedge clk_i);
    #1;
    waits++;
  end
  done  = apb_rsp.pready;
  rdata = apb_rsp.prdata;
  err   = apb_rsp.pslverr;
  @(negedge clk_i);
  apb_req = '0;
endtask

task automatic apb_write(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data,
                         output logic err, output logic done);
  logic [DataWidth-1:0] rdata;
  apb_xfer(1'b1, addr, data, rdata, err, done);
endtask

task automatic apb_read(input logic [AddrWidth-1:0] addr, output logic [DataWidth-1:0] data,
                        output logic err, output logic done);
  apb_xfer(1'b0, addr, '0, data, err, done);
endtask

`endif

// File: verif/hci_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the PIO queue core: runs a table of
// APB and controller steps against a queue model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module hci_tb;
  import hci_pkg::*;

  typedef enum logic [3:0] {
    op_sw_push, op_hw_pop, op_hw_push, op_sw_pop, op_stall_rd,
    op_thld, op_reset, op_rd, op_bad, op_check
  } op_e;

  typedef struct packed {
    op_e                  op;
    int unsigned          q;
    logic [DataWidth-1:0] arg;  // Register value or address
    logic [DataWidth-1:0] exp;  // Read data for op_rd
    int unsigned          cnt;  // Repeat count
  } step_t;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  apb_req_t             apb_req;
  apb_rsp_t             apb_rsp;
  logic                 cmd_rvalid, cmd_rready, tx_rvalid, tx_rready;
  logic [DataWidth-1:0] cmd_rdata, tx_rdata;
  logic                 resp_wvalid, resp_wready, rx_wvalid, rx_wready;
  logic [DataWidth-1:0] resp_wdata, rx_wdata;
  logic                 cmd_trig, tx_trig, resp_trig, rx_trig;

  step_t                steps [$];
  string                names [$];
  logic [DataWidth-1:0] model [NumQueues][$];  // Expected queue contents
  int unsigned          thld [NumQueues] = '{default: 0};
  int unsigned          checks = 0;
  int unsigned          errors = 0;
  int unsigned          limit_cycles = 0;
  logic                 table_ready = 1'b0;

  always #2 clk_i = ~clk_i;

  hci_top uut (
    .clk_i,
    .rst_ni,
    .apb_i            (apb_req),
    .apb_o            (apb_rsp),
    .cmd_rvalid_o     (cmd_rvalid),
    .cmd_rready_i     (cmd_rready),
    .cmd_rdata_o      (cmd_rdata),
    .tx_rvalid_o      (tx_rvalid),
    .tx_rready_i      (tx_rready),
    .tx_rdata_o       (tx_rdata),
    .resp_wvalid_i    (resp_wvalid),
    .resp_wready_o    (resp_wready),
    .resp_wdata_i     (resp_wdata),
    .rx_wvalid_i      (rx_wvalid),
    .rx_wready_o      (rx_wready),
    .rx_wdata_i       (rx_wdata),
    .cmd_thld_trig_o  (cmd_trig),
    .tx_thld_trig_o   (tx_trig),
    .resp_thld_trig_o (resp_trig),
    .rx_thld_trig_o   (rx_trig)
  );

  `include "hci_tb_apb.svh"

  task automatic add_step(input string name, input op_e op, input int unsigned q,
                          input logic [DataWidth-1:0] arg, input logic [DataWidth-1:0] exp,
                          input int unsigned cnt);
    steps.push_back(step_t'{op, q, arg, exp, cnt});
    names.push_back(name);
  endtask

  task automatic build_table();
    add_step("reset_state",     op_check,    0,     0,                   0,            1);
    add_step("unmapped_020",    op_bad,      0,     32'h020,             0,            1);
    add_step("unmapped_7f0",    op_bad,      0,     32'h7F0,             0,            1);
    add_step("unmapped_quiet",  op_check,    0,     0,                   0,            1);
    add_step("queue_thld",      op_thld,     QCmd,  32'h0000_030C,       0,            1);
    add_step("data_thld",       op_thld,     QTx,   32'h0000_100E,       0,            1);
    add_step("thld_readback",   op_rd,       0,     32'(RegQueueThld),   32'h0000_030C, 1);
    add_step("thld_idle",       op_check,    0,     0,                   0,            1);
    add_step("cmd_write",       op_sw_push,  QCmd,  0,                   0,            5);
    add_step("cmd_below_thld",  op_check,    0,     0,                   0,            1);
    add_step("tx_write",        op_sw_push,  QTx,   0,                   0,            3);
    add_step("cmd_drain",       op_hw_pop,   QCmd,  0,                   0,            2);
    add_step("cmd_above_thld",  op_check,    0,     0,                   0,            1);
    add_step("tx_drain",        op_hw_pop,   QTx,   0,                   0,            3);
    add_step("resp_push",       op_hw_push,  QResp, 0,                   0,            4);
    add_step("resp_above_thld", op_check,    0,     0,                   0,            1);
    add_step("resp_read",       op_sw_pop,   QResp, 0,                   0,            2);
    add_step("resp_below_thld", op_check,    0,     0,                   0,            1);
    add_step("rx_fill",         op_hw_push,  QRx,   0,                   0,            16);
    add_step("rx_full",         op_check,    0,     0,                   0,            1);
    add_step("rx_read",         op_sw_pop,   QRx,   0,                   0,            16);
    add_step("rx_stalled_read", op_stall_rd, QRx,   0,                   0,            1);
    add_step("cmd_soft_reset",  op_reset,    QCmd,  0,                   0,            1);
    add_step("cmd_flushed",     op_check,    0,     0,                   0,            1);
    add_step("reset_bit_clear", op_rd,       0,     32'(RegResetCtrl),   0,            1);
    add_step("resp_kept",       op_sw_pop,   QResp, 0,                   0,            2);
    add_step("thld_off_queue",  op_thld,     QCmd,  0,                   0,            1);
    add_step("thld_off_data",   op_thld,     QTx,   0,                   0,            1);
    add_step("final_state",     op_check,    0,     0,                   0,            1);
  endtask

  function automatic logic [AddrWidth-1:0] port_addr(input int unsigned q);
    case (q)
      QCmd:    return RegCmdPort;
      QTx:     return RegTxPort;
      QResp:   return RegRespPort;
      default: return RegRxPort;
    endcase
  endfunction

  // Status word from the model: trigger, full, empty nibbles
  function automatic logic [11:0] exp_status();
    logic [3:0]  emp;
    logic [3:0]  ful;
    logic [3:0]  trg;
    int unsigned lvl;
    int unsigned cnt;
    for (int i = 0; i < NumQueues; i++) begin
      lvl    = model[i].size();
      emp[i] = (lvl == 0);
      ful[i] = (lvl == QueueDepth);
      cnt    = (i == QCmd || i == QTx) ? QueueDepth - lvl : lvl;  // Free vs filled
      trg[i] = (thld[i] != 0) && (cnt >= thld[i]);
    end
    return {trg, ful, emp};
  endfunction

  task automatic check_val(input string name, input logic [DataWidth-1:0] exp,
                           input logic [DataWidth-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_xfer(input string name, input logic done, input logic err,
                            input logic exp_err);
    checks++;
    if (!done) begin
      errors++;
      $display("%s: APB transfer never completed", name);
    end else if (err !== exp_err) begin
      errors++;
      $display("error %s: expected pslverr %b, actual %b", name, exp_err, err);
    end
  endtask

  task automatic hw_push(input int unsigned q, input logic [DataWidth-1:0] word,
                         output logic ready);
    @(negedge clk_i);
    if (q == QResp) begin
      ready       = resp_wready;
      resp_wvalid = 1'b1;
      resp_wdata  = word;
    end else begin
      ready     = rx_wready;
      rx_wvalid = 1'b1;
      rx_wdata  = word;
    end
    @(negedge clk_i);
    resp_wvalid = 1'b0;
    rx_wvalid   = 1'b0;
  endtask

  task automatic hw_pop(input int unsigned q, output logic valid,
                        output logic [DataWidth-1:0] data);
    @(negedge clk_i);
    if (q == QCmd) begin
      valid      = cmd_rvalid;
      data       = cmd_rdata;
      cmd_rready = 1'b1;
    end else begin
      valid     = tx_rvalid;
      data      = tx_rdata;
      tx_rready = 1'b1;
    end
    @(negedge clk_i);
    cmd_rready = 1'b0;
    tx_rready  = 1'b0;
  endtask

  task automatic run_step(input int s);
    step_t                st;
    string                name;
    logic [DataWidth-1:0] word;
    logic [DataWidth-1:0] got;
    logic [11:0]          expst;
    logic                 err;
    logic                 done;
    logic                 flag;
    st   = steps[s];
    name = names[s];
    case (st.op)
      op_sw_push: begin
        word = $urandom;
        apb_write(port_addr(st.q), word, err, done);
        check_xfer(name, done, err, 1'b0);
        model[st.q].push_back(word);
      end
      op_hw_pop: begin
        hw_pop(st.q, flag, got);
        check_val({name, " rvalid"}, 1, 32'(flag));
        check_val(name, model[st.q].pop_front(), got);
      end
      op_hw_push: begin
        word = $urandom;
        hw_push(st.q, word, flag);
        check_val({name, " wready"}, 1, 32'(flag));
        model[st.q].push_back(word);
      end
      op_sw_pop: begin
        apb_read(port_addr(st.q), got, err, done);
        check_xfer(name, done, err, 1'b0);
        check_val(name, model[st.q].pop_front(), got);
      end
      op_stall_rd: begin
        word = $urandom;
        fork
          apb_read(port_addr(st.q), got, err, done);
          begin
            repeat (4) @(negedge clk_i);  // Read sits stalled meanwhile
            hw_push(st.q, word, flag);
          end
        join
        check_val({name, " wready"}, 1, 32'(flag));
        check_xfer(name, done, err, 1'b0);
        check_val(name, word, got);
      end
      op_thld: begin
        if (st.q == QCmd) begin
          apb_write(RegQueueThld, st.arg, err, done);
          thld[QCmd]  = 32'(st.arg[7:0]);
          thld[QResp] = 32'(st.arg[15:8]);
        end else begin
          apb_write(RegDataThld, st.arg, err, done);
          thld[QTx] = 32'(st.arg[7:0]);
          thld[QRx] = 32'(st.arg[15:8]);
        end
        check_xfer(name, done, err, 1'b0);
      end
      op_reset: begin
        apb_write(RegResetCtrl, 32'(4'b0001 << st.q), err, done);
        check_xfer(name, done, err, 1'b0);
        model[st.q].delete();
      end
      op_rd: begin
        apb_read(st.arg[AddrWidth-1:0], got, err, done);
        check_xfer(name, done, err, 1'b0);
        check_val(name, st.exp, got);
      end
      op_bad: begin
        apb_write(st.arg[AddrWidth-1:0], $urandom, err, done);
        check_xfer({name, " write"}, done, err, 1'b1);
        apb_read(st.arg[AddrWidth-1:0], got, err, done);
        check_xfer({name, " read"}, done, err, 1'b1);
        check_val(name, 0, got);
      end
      default: begin  // op_check
        expst = exp_status();
        @(negedge clk_i);
        check_val({name, " trig"}, 32'(expst[11:8]),
                  32'({rx_trig, resp_trig, tx_trig, cmd_trig}));
        check_val({name, " ports"}, 32'({~expst[7:6], ~expst[1:0]}),
                  32'({rx_wready, resp_wready, tx_rvalid, cmd_rvalid}));
        check_val({name, " idle"}, 0, 32'({apb_rsp.pready, apb_rsp.pslverr}));
        apb_read(RegStatus, got, err, done);
        check_xfer(name, done, err, 1'b0);
        check_val({name, " status"}, {20'b0, expst}, got);
      end
    endcase
  endtask

  initial begin : watchdog
    wait (table_ready);
    repeat (limit_cycles) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the run did not finish", limit_cycles);
    $display("checks %0d, errors %0d", checks, errors + 1);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    int unsigned total_ops;
    rst_ni      = 1'b0;
    apb_req     = '0;
    cmd_rready  = 1'b0;
    tx_rready   = 1'b0;
    resp_wvalid = 1'b0;
    resp_wdata  = '0;
    rx_wvalid   = 1'b0;
    rx_wdata    = '0;
    void'($urandom(32'hf745_ffd4));
    build_table();
    total_ops = 0;
    foreach (steps[s]) begin
      total_ops += steps[s].cnt;
    end
    limit_cycles = total_ops * 40 + 8;
    table_ready  = 1'b1;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    foreach (steps[s]) begin
      for (int unsigned n = 0; n < steps[s].cnt; n++) begin
        run_step(s);
      end
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
src/hci_pkg.sv
src/hci_queue.sv
src/hci_regs.sv
src/hci_top.sv
verif/hci_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -j 0 --top-module hci_tb -f sim.f -o hci_sim \
  && ./obj_dir/hci_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" \
  && echo "hci_tb run passed" \
  || { echo "hci_tb run failed"; exit 1; }
